// ==== sim.f ====
hw/axis_cfg_pkg.sv
hw/wb_csr_pkg.sv
hw/axis_frame_fifo.sv
hw/frame_stat_counters.sv
hw/wb_csr_fsm.sv
hw/axis_frame_buffer_top.sv
testbench/axis_frame_buffer_checker.sv
testbench/tb_axis_frame_buffer.sv

// ==== testbench/frame_stim.txt ====
# Columns: a command word, then its arguments.
# ctrl <value hex> | frame <length> <first hex> <step hex> <tuser> | stall <frames> | count <good> <bad> <ovf>
count 0 0 0
frame 1 a5 00 0
frame 4 10 01 0
frame 16 20 03 0
frame 7 f0 11 0
count 4 0 0
ctrl 1
frame 5 40 01 1
frame 3 50 02 0
count 5 1 0
ctrl 0
frame 5 60 01 1
count 6 1 0
frame 20 80 01 0
frame 2 c0 01 0
count 7 1 1
stall 4
frame 6 00 01 0
frame 6 30 01 0
frame 8 90 01 0
frame 3 d0 01 0
count 10 1 2
frame 9 01 07 0
frame 16 55 0b 0
frame 2 aa ff 0
frame 12 33 05 0
ctrl 1
frame 4 77 01 1
count 14 2 2
ctrl 2
count 0 0 0
ctrl 3
frame 3 e0 01 1
count 0 1 0

// ==== testbench/tb_axis_frame_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axis_frame_buffer;
  import axis_cfg_pkg::*;
  import wb_csr_pkg::*;

  localparam int fifo_depth = 2**fifo_addr_width;
  localparam int wait_limit = 400; // Cycles before any wait gives up.

  logic    clk = 1'b0;
  logic    rst;
  data_t   s_tdata;
  logic    s_tuser;
  logic    s_tlast;
  logic    s_tvalid;
  logic    s_tready;
  data_t   m_tdata;
  logic    m_tuser;
  logic    m_tlast;
  logic    m_tvalid;
  logic    m_tready;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  wb_adr_t wb_adr;
  wb_dat_t wb_dat_w;
  wb_dat_t wb_dat_r;
  logic    wb_ack;

  data_t exp_data[$];
  logic  exp_last[$];
  logic  exp_user[$];
  int    beats_expected = 0;
  int    beats_seen = 0;
  int    beat_errors = 0;
  int    count_errors = 0;
  int    wb_errors = 0;
  int    other_errors = 0;
  logic  aborted = 1'b0;
  logic  stall_on = 1'b0;
  int    stall_left = 0;
  int    stalled_occupancy = 0; // Beats committed while the output is held.
  logic  model_drop_bad = 1'b0;
  int    model_good = 0;
  int    model_bad = 0;
  int    model_ovf = 0;

  always #20 clk = ~clk;

  axis_frame_buffer_top i_dut (
    .clk(clk), .rst(rst),
    .s_tdata(s_tdata), .s_tuser(s_tuser), .s_tlast(s_tlast),
    .s_tvalid(s_tvalid), .s_tready(s_tready),
    .m_tdata(m_tdata), .m_tuser(m_tuser), .m_tlast(m_tlast),
    .m_tvalid(m_tvalid), .m_tready(m_tready),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  task automatic check_beat(input data_t exp_d, input data_t got_d,
                            input logic exp_l, input logic got_l,
                            input logic exp_u, input logic got_u);
    if (got_d !== exp_d) begin
      $display("[FAIL] m_tdata: expected 0x%0h, got 0x%0h", exp_d, got_d);
      beat_errors++;
    end
    if (got_l !== exp_l) begin
      $display("[FAIL] m_tlast: expected 0x%0h, got 0x%0h", exp_l, got_l);
      beat_errors++;
    end
    if (got_u !== exp_u) begin
      $display("[FAIL] m_tuser: expected 0x%0h, got 0x%0h", exp_u, got_u);
      beat_errors++;
    end
  endtask

  task automatic check_count(input string name, input cnt_t expected, input cnt_t got);
    if (got !== expected) begin
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, got);
      count_errors++;
    end
  endtask

  task automatic check_wb_data(input wb_dat_t expected, input wb_dat_t got);
    if (got !== expected) begin
      $display("[FAIL] wb_dat_r: expected 0x%0h, got 0x%0h", expected, got);
      wb_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    other_errors++;
    aborted = 1'b1;
  endtask

  // One classic cycle; the strobe drops on the cycle that shows ack.
  task automatic wb_transfer(input logic we, input wb_adr_t adr, input wb_dat_t wdata,
                             output wb_dat_t rdata);
    int cycles;
    cycles = 0;
    rdata = '0;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wb_ack && cycles < wait_limit);
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      report_timeout("wb_ack");
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  // Predicts whether a frame is forwarded, discarded as bad or dropped for space.
  task automatic model_frame(input int len, input data_t first, input data_t step,
                             input logic user);
    int space;
    data_t value;
    space = (stall_left > 0) ? fifo_depth - stalled_occupancy : fifo_depth;
    value = first;
    if (len > space) begin
      model_ovf++;
    end else if ((user == user_bad_value) && model_drop_bad) begin
      model_bad++;
    end else begin
      model_good++;
      for (int i = 0; i < len; i++) begin
        exp_data.push_back(value);
        exp_last.push_back(i == len - 1);
        exp_user.push_back((i == len - 1) ? user : 1'b0);
        value = value + step;
      end
      beats_expected += len;
      if (stall_left > 0) stalled_occupancy += len;
    end
  endtask

  task automatic send_frame(input int len, input data_t first, input data_t step,
                            input logic user);
    int cycles;
    data_t value;
    value = first;
    for (int i = 0; i < len && !aborted; i++) begin
      @(negedge clk);
      s_tvalid = 1'b1;
      s_tdata = value;
      s_tlast = (i == len - 1);
      s_tuser = (i == len - 1) ? user : 1'b0; // Only the last beat carries the flag.
      cycles = 0;
      while (!s_tready && !aborted) begin
        @(negedge clk);
        cycles++;
        if (cycles > wait_limit) report_timeout("s_tready");
      end
      value = value + step;
    end
    @(negedge clk);
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
    s_tuser = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (beats_seen < beats_expected && !aborted) begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) report_timeout("the output to drain");
    end
  endtask

  // Sink. The beat seen here transfers on the next rising edge.
  initial begin
    logic ready;
    void'($urandom(94718));
    m_tready = 1'b0;
    forever begin
      @(negedge clk);
      ready = !stall_on && ($urandom_range(3) != 0);
      m_tready = ready;
      if (!rst && ready && m_tvalid) begin
        if (exp_data.size() == 0) begin
          $display("ERROR: output beat 0x%0h arrived with no frame expected", m_tdata);
          beat_errors++;
        end else begin
          check_beat(exp_data.pop_front(), m_tdata, exp_last.pop_front(), m_tlast,
                     exp_user.pop_front(), m_tuser);
        end
        beats_seen++;
      end
    end
  end

  initial begin
    int fd;
    int code;
    string cmd;
    string rest;
    int len;
    int first;
    int step;
    int user;
    int frames;
    int ctrl_value;
    int good;
    int bad;
    int ovf;
    wb_dat_t rdata;
    wb_dat_t expected_ctrl;
    rst = 1'b1;
    s_tdata = '0;
    s_tuser = 1'b0;
    s_tlast = 1'b0;
    s_tvalid = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fd = $fopen("testbench/frame_stim.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the stimulus file");
      other_errors++;
    end
    while (fd != 0 && !aborted && $fscanf(fd, "%s", cmd) == 1) begin
      case (cmd)
        "#": code = $fgets(rest, fd);
        "ctrl": begin
          code = $fscanf(fd, "%h", ctrl_value);
          wb_transfer(1'b1, adr_ctrl, wb_dat_t'(ctrl_value), rdata);
          model_drop_bad = ctrl_value[ctrl_drop_bad_bit];
          if (ctrl_value[ctrl_clear_bit]) begin
            model_good = 0;
            model_bad = 0;
            model_ovf = 0;
          end
          expected_ctrl = '0;
          expected_ctrl[ctrl_drop_bad_bit] = model_drop_bad;
          wb_transfer(1'b0, adr_ctrl, '0, rdata);
          check_wb_data(expected_ctrl, rdata);
        end
        "frame": begin
          code = $fscanf(fd, "%d %h %h %d", len, first, step, user);
          model_frame(len, data_t'(first), data_t'(step), user[0]);
          send_frame(len, data_t'(first), data_t'(step), user[0]);
          if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
              stall_on <= 1'b0;
              stalled_occupancy = 0;
              wait_drain();
            end
          end else begin
            wait_drain();
          end
        end
        "stall": begin
          code = $fscanf(fd, "%d", frames);
          stall_left = frames;
          stalled_occupancy = 0;
          if (frames > 0) stall_on <= 1'b1;
        end
        "count": begin
          code = $fscanf(fd, "%d %d %d", good, bad, ovf);
          if (good != model_good || bad != model_bad || ovf != model_ovf) begin
            $display("ERROR: stimulus file counts disagree with the reference model");
            other_errors++;
          end
          wb_transfer(1'b0, adr_good, '0, rdata);
          check_count("good_count", cnt_t'(good), cnt_t'(rdata));
          wb_transfer(1'b0, adr_bad, '0, rdata);
          check_count("bad_count", cnt_t'(bad), cnt_t'(rdata));
          wb_transfer(1'b0, adr_ovf, '0, rdata);
          check_count("ovf_count", cnt_t'(ovf), cnt_t'(rdata));
        end
        default: begin
          $display("ERROR: unknown stimulus command %s", cmd);
          other_errors++;
          aborted = 1'b1;
        end
      endcase
    end
    if (fd != 0) $fclose(fd);
    wait_drain();
    repeat (8) @(negedge clk); // Lets any stray beat show up.
    $display("Errors: beats %0d, counters %0d, wishbone %0d, other %0d",
             beat_errors, count_errors, wb_errors, other_errors);
    if (beat_errors + count_errors + wb_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/axis_frame_buffer_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_frame_buffer_checker (
  input logic                clk,
  input logic                rst,
  input axis_cfg_pkg::data_t m_tdata,
  input logic                m_tlast,
  input logic                m_tvalid,
  input logic                m_tready,
  input logic                wb_cyc,
  input logic                wb_stb,
  input logic                wb_ack
);

  // A stalled output beat holds until the sink takes it.
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast)))
    else $error("Output beat dropped or changed while m_tready was low.");

  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else $error("wb_ack was high for two cycles in a row.");

  a_ack_request: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack rose without a preceding cyc and stb.");

endmodule

bind axis_frame_buffer_top axis_frame_buffer_checker i_checker (
  .clk(clk),
  .rst(rst),
  .m_tdata(m_tdata),
  .m_tlast(m_tlast),
  .m_tvalid(m_tvalid),
  .m_tready(m_tready),
  .wb_cyc(wb_cyc),
  .wb_stb(wb_stb),
  .wb_ack(wb_ack)
);

`default_nettype wire

// ==== hw/axis_frame_buffer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_frame_buffer_top (
  input  logic                clk,
  input  logic                rst,

  input  axis_cfg_pkg::data_t s_tdata,
  input  logic                s_tuser,
  input  logic                s_tlast,
  input  logic                s_tvalid,
  output logic                s_tready,

  output axis_cfg_pkg::data_t m_tdata,
  output logic                m_tuser,
  output logic                m_tlast,
  output logic                m_tvalid,
  input  logic                m_tready,

  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  wb_csr_pkg::wb_adr_t wb_adr,
  input  wb_csr_pkg::wb_dat_t wb_dat_w,
  output wb_csr_pkg::wb_dat_t wb_dat_r,
  output logic                wb_ack
);
  import axis_cfg_pkg::*;

  logic status_good;
  logic status_bad;
  logic status_overflow;
  logic drop_bad; // Level from the control register.
  logic clear;    // Single-cycle pulse.
  cnt_t good_count;
  cnt_t bad_count;
  cnt_t ovf_count;

  axis_frame_fifo #(
    .addr_width(fifo_addr_width)
  ) i_fifo (
    .clk(clk),
    .rst(rst),
    .s_tdata(s_tdata),
    .s_tuser(s_tuser),
    .s_tlast(s_tlast),
    .s_tvalid(s_tvalid),
    .s_tready(s_tready),
    .m_tdata(m_tdata),
    .m_tuser(m_tuser),
    .m_tlast(m_tlast),
    .m_tvalid(m_tvalid),
    .m_tready(m_tready),
    .drop_bad(drop_bad),
    .status_good(status_good),
    .status_bad(status_bad),
    .status_overflow(status_overflow)
  );

  frame_stat_counters i_stats (
    .clk(clk),
    .rst(rst),
    .clear(clear),
    .status_good(status_good),
    .status_bad(status_bad),
    .status_overflow(status_overflow),
    .good_count(good_count),
    .bad_count(bad_count),
    .ovf_count(ovf_count)
  );

  wb_csr_fsm i_csr (
    .clk(clk),
    .rst(rst),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack),
    .good_count(good_count),
    .bad_count(bad_count),
    .ovf_count(ovf_count),
    .drop_bad(drop_bad),
    .clear(clear)
  );

endmodule

`default_nettype wire

// ==== hw/wb_csr_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_csr_fsm (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_csr_pkg::wb_adr_t  wb_adr,
  input  wb_csr_pkg::wb_dat_t  wb_dat_w,
  output wb_csr_pkg::wb_dat_t  wb_dat_r,
  output logic                 wb_ack,

  input  axis_cfg_pkg::cnt_t   good_count,
  input  axis_cfg_pkg::cnt_t   bad_count,
  input  axis_cfg_pkg::cnt_t   ovf_count,
  output logic                 drop_bad,
  output logic                 clear
);
  import wb_csr_pkg::*;

  typedef enum logic {
    st_idle,
    st_ack
  } state_t;

  state_t  state_q;
  logic    drop_bad_q;
  logic    clear_q;
  wb_dat_t rd_data;
  wb_dat_t dat_r_q;
  logic    access;

  assign access = (state_q == st_idle) && wb_cyc && wb_stb;

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      adr_ctrl: rd_data[ctrl_drop_bad_bit] = drop_bad_q; // Clear bit stays 0.
      adr_good: rd_data = good_count;
      adr_bad:  rd_data = bad_count;
      adr_ovf:  rd_data = ovf_count;
      default:  rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      drop_bad_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (access) begin
            state_q <= st_ack;
            if (wb_we && (wb_adr == adr_ctrl)) begin
              drop_bad_q <= wb_dat_w[ctrl_drop_bad_bit];
              clear_q <= wb_dat_w[ctrl_clear_bit];
            end
          end
        end
        default: state_q <= st_idle; // One idle cycle between accesses.
      endcase
    end
  end

  // Read data is captured on the same edge that raises ack.
  always_ff @(posedge clk) begin
    if (access) begin
      dat_r_q <= rd_data;
    end
  end

  assign wb_ack = (state_q == st_ack);
  assign wb_dat_r = dat_r_q;
  assign drop_bad = drop_bad_q;
  assign clear = clear_q;

endmodule

`default_nettype wire

// ==== hw/frame_stat_counters.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_stat_counters (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear,
  input  logic               status_good,
  input  logic               status_bad,
  input  logic               status_overflow,
  output axis_cfg_pkg::cnt_t good_count,
  output axis_cfg_pkg::cnt_t bad_count,
  output axis_cfg_pkg::cnt_t ovf_count
);
  import axis_cfg_pkg::*;

  cnt_t good_q;
  cnt_t bad_q;
  cnt_t ovf_q;

  // Counts up on a pulse and sticks at all ones.
  function automatic cnt_t sat_inc(input cnt_t value, input logic pulse);
    cnt_t result;
    result = value;
    if (pulse && (value != '1)) begin
      result = value + 1'b1;
    end
    return result;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || clear) begin // Clear wins over a pulse in the same cycle.
      good_q <= '0;
      bad_q <= '0;
      ovf_q <= '0;
    end else begin
      good_q <= sat_inc(good_q, status_good);
      bad_q <= sat_inc(bad_q, status_bad);
      ovf_q <= sat_inc(ovf_q, status_overflow);
    end
  end

  assign good_count = good_q;
  assign bad_count = bad_q;
  assign ovf_count = ovf_q;

endmodule

`default_nettype wire

// ==== hw/axis_frame_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_frame_fifo #(
  parameter int addr_width = axis_cfg_pkg::fifo_addr_width
) (
  input  logic                clk,
  input  logic                rst,

  input  axis_cfg_pkg::data_t s_tdata,
  input  logic                s_tuser,
  input  logic                s_tlast,
  input  logic                s_tvalid,
  output logic                s_tready,

  output axis_cfg_pkg::data_t m_tdata,
  output logic                m_tuser,
  output logic                m_tlast,
  output logic                m_tvalid,
  input  logic                m_tready,

  input  logic                drop_bad,
  output logic                status_good,
  output logic                status_bad,
  output logic                status_overflow
);
  import axis_cfg_pkg::*;

  typedef logic [addr_width:0] ptr_t;

  logic [entry_width-1:0] mem [2**addr_width];

  ptr_t wr_ptr_q;        // End of the last committed frame.
  ptr_t wr_ptr_cur_q;    // Next free slot of the frame being written.
  ptr_t wr_ptr_commit_q; // Committed pointer as seen by the read side.
  ptr_t rd_ptr_q;
  ptr_t wr_ptr_next;
  ptr_t wr_ptr_cur_next;

  logic drop_frame_q;
  logic drop_frame_next;
  logic good_q;
  logic good_next;
  logic bad_q;
  logic bad_next;
  logic ovf_q;
  logic ovf_next;

  logic write;
  logic read;
  logic store_output;
  logic full_cur;
  logic empty;
  logic frame_bad;

  logic [entry_width-1:0] mem_data_q;
  logic                   mem_valid_q;
  logic                   mem_valid_next;
  logic [entry_width-1:0] out_data_q;
  logic                   out_valid_q;

  // A frame that runs into a full FIFO is consumed and thrown away, so the input
  // never has to stall.
  assign s_tready = 1'b1;

  // No room for another beat of the current frame.
  assign full_cur = (wr_ptr_cur_q[addr_width] != rd_ptr_q[addr_width]) &&
                    (wr_ptr_cur_q[addr_width-1:0] == rd_ptr_q[addr_width-1:0]);
  assign empty = (wr_ptr_commit_q == rd_ptr_q);
  assign frame_bad = drop_bad && (s_tuser == user_bad_value);

  always_comb begin
    write = 1'b0;
    wr_ptr_next = wr_ptr_q;
    wr_ptr_cur_next = wr_ptr_cur_q;
    drop_frame_next = drop_frame_q;
    good_next = 1'b0;
    bad_next = 1'b0;
    ovf_next = 1'b0;
    if (s_tvalid && s_tready) begin
      if (full_cur || drop_frame_q) begin
        drop_frame_next = 1'b1;
        if (s_tlast) begin
          wr_ptr_cur_next = wr_ptr_q; // Roll back to the last committed frame.
          drop_frame_next = 1'b0;
          ovf_next = 1'b1;
        end
      end else begin
        write = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur_q + 1'b1;
        if (s_tlast) begin
          if (frame_bad) begin
            wr_ptr_cur_next = wr_ptr_q;
            bad_next = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur_q + 1'b1; // Commit the whole frame.
            good_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      wr_ptr_cur_q <= '0;
      wr_ptr_commit_q <= '0;
      drop_frame_q <= 1'b0;
      good_q <= 1'b0;
      bad_q <= 1'b0;
      ovf_q <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_next;
      wr_ptr_cur_q <= wr_ptr_cur_next;
      wr_ptr_commit_q <= wr_ptr_q;
      drop_frame_q <= drop_frame_next;
      good_q <= good_next;
      bad_q <= bad_next;
      ovf_q <= ovf_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur_q[addr_width-1:0]] <= {s_tlast, s_tuser, s_tdata};
    end
  end

  // The output register loads whenever it is empty or its beat is taken.
  assign store_output = m_tready || !out_valid_q;

  always_comb begin
    read = 1'b0;
    mem_valid_next = mem_valid_q;
    if (store_output || !mem_valid_q) begin
      read = !empty;
      mem_valid_next = !empty;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= '0;
      mem_valid_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      mem_valid_q <= mem_valid_next;
      if (store_output) begin
        out_valid_q <= mem_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_data_q <= mem[rd_ptr_q[addr_width-1:0]];
    end
    if (store_output) begin
      out_data_q <= mem_data_q;
    end
  end

  assign m_tdata = out_data_q[data_width-1:0];
  assign m_tuser = out_data_q[data_width +: user_width];
  assign m_tlast = out_data_q[entry_width-1];
  assign m_tvalid = out_valid_q;

  assign status_good = good_q;
  assign status_bad = bad_q;
  assign status_overflow = ovf_q;

endmodule

`default_nettype wire

// ==== hw/wb_csr_pkg.sv ====
`default_nettype none

package wb_csr_pkg;

  localparam int wb_adr_width = 2; // Word address.
  localparam int wb_dat_width = 16;

  typedef logic [wb_adr_width-1:0] wb_adr_t;
  typedef logic [wb_dat_width-1:0] wb_dat_t;

  // Register map.
  localparam wb_adr_t adr_ctrl = 2'd0;
  localparam wb_adr_t adr_good = 2'd1;
  localparam wb_adr_t adr_bad = 2'd2;
  localparam wb_adr_t adr_ovf = 2'd3;

  // Control register bits. The clear bit is write-only and reads as 0.
  localparam int ctrl_drop_bad_bit = 0;
  localparam int ctrl_clear_bit = 1;

endpackage

`default_nettype wire

// ==== hw/axis_cfg_pkg.sv ====
`default_nettype none

package axis_cfg_pkg;

  localparam int data_width = 8;
  localparam int fifo_addr_width = 4; // 16 entries by default.
  localparam int user_width = 1;
  localparam int cnt_width = 16;

  // One FIFO entry carries tdata, tuser and tlast.
  localparam int entry_width = data_width + user_width + 1;

  // A last beat with this tuser value marks the frame as bad.
  localparam logic [user_width-1:0] user_bad_value = 1'b1;

  typedef logic [data_width-1:0] data_t;
  typedef logic [cnt_width-1:0] cnt_t;

endpackage

`default_nettype wire
